// File: all.f
+incdir+testbench
logic/cpuPkg.sv
logic/registerFile.sv
logic/fetchUnit.sv
logic/decodeUnit.sv
logic/executeUnit.sv
logic/memoryUnit.sv
logic/pipelinedCore.sv
testbench/coreTb.sv

// File: Bender.yml
package:
  name: pipelined_core

sources:
  - logic/cpuPkg.sv
  - logic/registerFile.sv
  - logic/fetchUnit.sv
  - logic/decodeUnit.sv
  - logic/executeUnit.sv
  - logic/memoryUnit.sv
  - logic/pipelinedCore.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/coreTb.sv

// File: testbench/isaModel.svh
/*
  Random program generator and instruction-level model, included inside coreTb.
  Works on the including module's instrMem, modelMem, expectAddr and expectData
  and on its bodyLen, progLen, instrDepth and dataDepth constants.
  Registers used are r0-r6. Branches only go forward, so the program always ends.
  The tail stores r0-r6 through r7, i.e. to address zero, then branches to itself.
*/
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

localparam logic [15:0] nopWord  = {cpuPkg::opOther, 13'h0000};
localparam logic [15:0] selfLoop = {cpuPkg::opMvtB, 1'b0, 3'd0, 9'h1ff}; // b -1

function automatic logic [15:0] immForm(input logic [2:0] op, input logic m,
                                        input logic [2:0] rx, input logic [8:0] imm);
    return {op, m, rx, imm};
endfunction

function automatic logic [15:0] regForm(input logic [2:0] op, input logic [2:0] rx,
                                        input logic [2:0] ry);
    return {op, 1'b0, rx, 6'h00, ry};
endfunction

function automatic logic [15:0] signExtend(input logic [8:0] imm);
    return {{7{imm[8]}}, imm};
endfunction

task automatic generateProgram();
    int         pc;
    int         kind;
    int         offset;
    logic [2:0] op;
    logic [2:0] rx;
    logic [2:0] ry;
    logic       m;
    for (int i = 0; i < instrDepth; i++)
        instrMem[i] = nopWord;                     // fetches past the end see no-ops
    pc = 0;
    while (pc < bodyLen) begin
        kind = $urandom % 10;
        rx   = 3'($urandom % 7);
        ry   = 3'($urandom % 7);
        m    = 1'($urandom);
        case (kind)
            0, 1, 2, 3: begin                      // mv add sub and
                op = (kind == 0) ? cpuPkg::opMv : (kind == 1) ? cpuPkg::opAdd
                   : (kind == 2) ? cpuPkg::opSub : cpuPkg::opAnd;
                instrMem[pc] = m ? immForm(op, 1'b1, rx, 9'($urandom)) : regForm(op, rx, ry);
            end
            4: instrMem[pc] = immForm(cpuPkg::opMvtB, 1'b1, rx, 9'($urandom));
            5: instrMem[pc] = regForm(cpuPkg::opLd, rx, ry);
            6: instrMem[pc] = regForm(cpuPkg::opSt, rx, ry);
            7: instrMem[pc] = {cpuPkg::opOther, 13'($urandom)};
            8: begin                               // forward branch, stays inside the body
                offset = $urandom % 4;
                if (pc + 1 + offset > bodyLen)
                    offset = bodyLen - pc - 1;
                instrMem[pc] = immForm(cpuPkg::opMvtB, 1'b0, 3'd0, 9'(offset));
            end
            default: begin
                // small address then ld or st through it, so loads hit earlier stores
                instrMem[pc] = immForm(cpuPkg::opMv, 1'b1, ry, 9'($urandom % 16));
                if (pc + 1 < bodyLen) begin
                    pc++;
                    instrMem[pc] = regForm(m ? cpuPkg::opLd : cpuPkg::opSt, rx, ry);
                end
            end
        endcase
        pc++;
    end
    for (int k = 0; k < 7; k++)
        instrMem[bodyLen + k] = regForm(cpuPkg::opSt, 3'(k), 3'd7);
    instrMem[bodyLen + 7] = selfLoop;
endtask

// runs the program one instruction at a time, fills the expected store stream
task automatic runModel();
    logic [15:0] regs [8];
    logic [15:0] pc;
    logic [15:0] instr;
    logic [15:0] opB;
    logic [15:0] addr;
    logic [15:0] value;
    logic [2:0]  rx;
    logic        writes;
    int          steps;
    for (int i = 0; i < 8; i++)
        regs[i] = '0;                              // r7 is never written, reads zero
    pc    = '0;
    steps = 0;
    instr = instrMem[0];
    while (instr != selfLoop && steps < 2 * progLen) begin
        rx     = instr[11:9];
        opB    = instr[12] ? signExtend(instr[8:0]) : regs[instr[2:0]];
        addr   = regs[instr[2:0]];                 // ld/st always use rY
        value  = '0;
        writes = 1'b1;
        pc     = pc + 1'b1;
        case (instr[15:13])
            cpuPkg::opMv:  value = opB;
            cpuPkg::opAdd: value = regs[rx] + opB;
            cpuPkg::opSub: value = regs[rx] - opB;
            cpuPkg::opAnd: value = regs[rx] & opB;
            cpuPkg::opLd:  value = modelMem[addr % dataDepth];
            cpuPkg::opMvtB: begin
                if (instr[12]) begin
                    value = {instr[7:0], 8'h00};
                end else begin
                    writes = 1'b0;
                    pc     = pc + signExtend(instr[8:0]); // own address plus one plus offset
                end
            end
            cpuPkg::opSt: begin
                writes = 1'b0;
                modelMem[addr % dataDepth] = regs[rx];
                expectAddr.push_back(addr);
                expectData.push_back(regs[rx]);
            end
            default: writes = 1'b0;                // opOther
        endcase
        if (writes && rx != 3'd7)
            regs[rx] = value;
        steps++;
        instr = instrMem[pc % instrDepth];
    end
endtask

`endif

// File: testbench/coreTb.sv
/*
  Random-program test of pipelinedCore against an instruction-level model.
  Instruction memory answers one cycle after InstrAddr. A data request is taken on an
  edge with DataDone high, and DataDone is redrawn each cycle at 60 percent.
  Data addresses wrap at dataDepth words, here and in the model alike.
  Only the store stream is compared. The program tail stores every register.
*/
module coreTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int seed          = 36;
    localparam int bodyLen       = 80;             // random part of the program
    localparam int tailLen       = 8;              // seven stores and the final loop
    localparam int progLen       = bodyLen + tailLen;
    localparam int instrDepth    = 128;
    localparam int dataDepth     = 256;
    localparam int clockPeriod   = 4;
    localparam int timeoutCycles = 20 * progLen;
    localparam int drainCycles   = 40;             // idle time after the last store

    logic        Clock    = 1'b0;
    logic        Reset    = 1'b1;
    logic [15:0] InstrIn  = '0;
    logic [15:0] InstrAddr;
    logic [15:0] DataIn   = '0;
    logic        DataDone = 1'b0;
    logic [15:0] DataAddr;
    logic [15:0] DataOut;
    logic        ReadData;
    logic        WriteData;

    logic [15:0] instrMem [instrDepth];
    logic [15:0] dataMem  [dataDepth];
    logic [15:0] modelMem [dataDepth];             // model's own copy of the data memory
    logic [15:0] expectAddr [$];
    logic [15:0] expectData [$];
    int          modelStores;
    int          storeCount = 0;
    int          errorCount = 0;

    `include "isaModel.svh"

    pipelinedCore #(.ResetPc(16'h0000)) u_pipelinedCore (
        .Clock, .Reset, .InstrIn, .InstrAddr, .DataIn, .DataDone,
        .DataAddr, .DataOut, .ReadData, .WriteData
    );

    initial begin
        forever #(clockPeriod / 2) Clock = ~Clock;
    end

    // fixed one-cycle instruction read
    always @(posedge Clock) begin
        InstrIn <= instrMem[InstrAddr % instrDepth];
    end

    always @(posedge Clock) begin
        DataDone <= ($urandom % 100) < 60;         // random back-pressure
        if (!Reset && DataDone && ReadData)
            DataIn <= dataMem[DataAddr % dataDepth]; // visible one cycle after acceptance
        if (!Reset && DataDone && WriteData) begin
            dataMem[DataAddr % dataDepth] <= DataOut;
            checkStore(DataAddr, DataOut);
        end
    end

    // compare one accepted store with the head of the model's stream
    task automatic checkStore(input logic [15:0] addr, input logic [15:0] data);
        logic [15:0] wantAddr;
        logic [15:0] wantData;
        storeCount++;
        assert (expectAddr.size() > 0) else begin
            errorCount++;
            $display("store of %h to %h has no counterpart in the model", data, addr);
        end
        if (expectAddr.size() > 0) begin
            wantAddr = expectAddr.pop_front();
            wantData = expectData.pop_front();
            assert (addr == wantAddr) else begin
                errorCount++;
                $display("error: DataAddr expected %h got %h (store %0d)",
                         wantAddr, addr, storeCount);
            end
            assert (data == wantData) else begin
                errorCount++;
                $display("error: DataOut expected %h got %h (store %0d)",
                         wantData, data, storeCount);
            end
        end
    endtask

    task automatic finishRun();
        $display("stores seen %0d, model stores %0d, errors %0d",
                 storeCount, modelStores, errorCount);
        if (errorCount == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    endtask

    initial begin
        void'($urandom(seed));
        generateProgram();
        for (int i = 0; i < dataDepth; i++)
            dataMem[i] = 16'($urandom);
        modelMem = dataMem;
        runModel();
        modelStores = expectAddr.size();
        repeat (2) @(posedge Clock);
        // still in reset here, outputs settled
        assert (!ReadData) else begin
            errorCount++;
            $display("error: ReadData expected %h got %h", 1'b0, ReadData);
        end
        assert (!WriteData) else begin
            errorCount++;
            $display("error: WriteData expected %h got %h", 1'b0, WriteData);
        end
        assert (InstrAddr == 16'h0000) else begin
            errorCount++;
            $display("error: InstrAddr expected %h got %h", 16'h0000, InstrAddr);
        end
        Reset <= 1'b0;
        while (storeCount < modelStores)
            @(posedge Clock);
        repeat (drainCycles) @(posedge Clock); // core spins on its loop, no more stores
        assert (storeCount == modelStores) else begin
            errorCount++;
            $display("core made %0d stores but the model expects %0d", storeCount, modelStores);
        end
        finishRun();
    end

    // watchdog
    initial begin
        #(timeoutCycles * clockPeriod);
        errorCount++;
        $display("core did not finish within %0d cycles", timeoutCycles);
        finishRun();
    end

endmodule

// File: logic/pipelinedCore.sv
/*
  Six-stage in-order core, no forwarding. Instruction port is a fixed one-cycle read,
  the data port is valid/ready with DataDone as ready.
  Load data must arrive on DataIn exactly one cycle after the accepting edge.
*/
module pipelinedCore #(
    parameter logic [cpuPkg::wordSize-1:0] ResetPc = '0
) (
    input  logic                        Clock,
    input  logic                        Reset,
    input  logic [cpuPkg::wordSize-1:0] InstrIn,
    output logic [cpuPkg::wordSize-1:0] InstrAddr,
    input  logic [cpuPkg::wordSize-1:0] DataIn,
    input  logic                        DataDone,
    output logic [cpuPkg::wordSize-1:0] DataAddr,
    output logic [cpuPkg::wordSize-1:0] DataOut,
    output logic                        ReadData,
    output logic                        WriteData
);

    logic [cpuPkg::wordSize-1:0] fetchedInstr, fetchedPc, branchTarget;
    logic [cpuPkg::wordSize-1:0] readDataA, readDataB, writeValue;
    logic [cpuPkg::regBits-1:0]  readRegA, readRegB, writeReg;
    logic [cpuPkg::regBits-1:0]  mem1Rx, mem2Rx, wbRx;
    logic                        fetchedValid, hazardStall, memStall, branchTaken;
    logic                        writeEnable, mem1Writes, mem2Writes, wbWrites;
    cpuPkg::StageRecord          decodeRecord, executeRecord;

    registerFile u_registerFile (
        .Clock, .Reset, .readRegA, .readRegB, .writeEnable, .writeReg, .writeValue,
        .readDataA, .readDataB
    );

    fetchUnit #(.ResetPc(ResetPc)) u_fetchUnit (
        .Clock, .Reset, .InstrIn, .hazardStall, .memStall, .branchTaken, .branchTarget,
        .InstrAddr, .fetchedInstr, .fetchedValid, .fetchedPc
    );

    decodeUnit u_decodeUnit (
        .Clock, .Reset, .fetchedInstr, .fetchedValid, .fetchedPc, .readDataA, .readDataB,
        .memStall, .branchTaken, .executeRecord,
        .mem1Rx, .mem1Writes, .mem2Rx, .mem2Writes, .wbRx, .wbWrites,
        .readRegA, .readRegB, .decodeRecord, .hazardStall
    );

    executeUnit u_executeUnit (
        .Clock, .Reset, .decodeRecord, .memStall, .executeRecord, .branchTaken, .branchTarget
    );

    memoryUnit u_memoryUnit (
        .Clock, .Reset, .executeRecord, .DataIn, .DataDone,
        .DataAddr, .DataOut, .ReadData, .WriteData, .memStall,
        .writeEnable, .writeReg, .writeValue,
        .mem1Rx, .mem1Writes, .mem2Rx, .mem2Writes, .wbRx, .wbWrites
    );

endmodule

// File: logic/memoryUnit.sv
/*
  Memory1 drives the data request from the Execute register, Memory2 takes the load word,
  Writeback writes the register file. DataDone low stalls the whole pipeline.
  Load data is valid only in the cycle after acceptance. If Memory2 is held then,
  the word is kept in its record.
*/
module memoryUnit (
    input  logic                        Clock,
    input  logic                        Reset,
    input  cpuPkg::StageRecord          executeRecord,
    input  logic [cpuPkg::wordSize-1:0] DataIn,
    input  logic                        DataDone,
    output logic [cpuPkg::wordSize-1:0] DataAddr,
    output logic [cpuPkg::wordSize-1:0] DataOut,
    output logic                        ReadData,
    output logic                        WriteData,
    output logic                        memStall,
    output logic                        writeEnable,
    output logic [cpuPkg::regBits-1:0]  writeReg,
    output logic [cpuPkg::wordSize-1:0] writeValue,
    output logic [cpuPkg::regBits-1:0]  mem1Rx,
    output logic                        mem1Writes,
    output logic [cpuPkg::regBits-1:0]  mem2Rx,
    output logic                        mem2Writes,
    output logic [cpuPkg::regBits-1:0]  wbRx,
    output logic                        wbWrites
);

    cpuPkg::StageRecord          mem1Record; // in Memory2
    cpuPkg::StageRecord          mem2Record; // in Writeback
    cpuPkg::StageRecord          wbRecord;   // retired
    logic                        mem1Fresh;  // DataIn belongs to mem1Record this cycle
    logic [cpuPkg::wordSize-1:0] loadValue;

    // request straight from the Execute register, held there by memStall
    assign ReadData  = executeRecord.valid && executeRecord.read;
    assign WriteData = executeRecord.valid && executeRecord.write;
    assign DataAddr  = executeRecord.op2;
    assign DataOut   = executeRecord.op1;                 // store data is rX
    assign memStall  = (ReadData || WriteData) && !DataDone;

    assign loadValue = (mem1Fresh && mem1Record.read) ? DataIn : mem1Record.result;

    always_ff @(posedge Clock, posedge Reset) begin
        if (Reset) begin
            mem1Record <= '0;
            mem2Record <= '0;
            wbRecord   <= '0;
            mem1Fresh  <= 1'b0;
        end else if (!memStall) begin
            mem1Record        <= executeRecord;
            mem2Record        <= mem1Record;
            mem2Record.result <= loadValue;
            wbRecord          <= mem2Record;
            mem1Fresh         <= 1'b1;
        end else begin
            mem1Record.result <= loadValue; // catch the load word before DataIn moves on
            mem1Fresh         <= 1'b0;
        end
    end

    // one write per instruction, none while the pipeline is held
    assign writeEnable = mem2Record.valid && mem2Record.writeback && !memStall;
    assign writeReg    = mem2Record.rX;
    assign writeValue  = mem2Record.result;

    assign mem1Rx     = mem1Record.rX;
    assign mem1Writes = mem1Record.valid && mem1Record.writeback;
    assign mem2Rx     = mem2Record.rX;
    assign mem2Writes = mem2Record.valid && mem2Record.writeback;
    assign wbRx       = wbRecord.rX;
    assign wbWrites   = wbRecord.valid && wbRecord.writeback;

    // a refused request must not change until the memory takes it
    requestStable: assert property (@(posedge Clock) disable iff (Reset)
        (ReadData || WriteData) && !DataDone
            |=> $stable({ReadData, WriteData, DataAddr, DataOut}));

endmodule

// File: logic/executeUnit.sv
/*
  ALU and branch resolution. A branch goes through the ALU as PC plus offset,
  and its target is that sum plus one. branchTaken is a single-cycle pulse,
  held off while the memory side stalls so the redirect happens once.
*/
module executeUnit (
    input  logic                        Clock,
    input  logic                        Reset,
    input  cpuPkg::StageRecord          decodeRecord,
    input  logic                        memStall,
    output cpuPkg::StageRecord          executeRecord,
    output logic                        branchTaken,
    output logic [cpuPkg::wordSize-1:0] branchTarget
);

    logic [cpuPkg::wordSize-1:0] aluResult;

    always_comb begin
        case (decodeRecord.aluOp)
            cpuPkg::aluMov: aluResult = decodeRecord.op2;
            cpuPkg::aluAdd: aluResult = decodeRecord.op1 + decodeRecord.op2;
            cpuPkg::aluSub: aluResult = decodeRecord.op1 - decodeRecord.op2;
            cpuPkg::aluAnd: aluResult = decodeRecord.op1 & decodeRecord.op2;
            default:        aluResult = '0; // ld/st keep their address in op2
        endcase
    end

    assign branchTaken  = decodeRecord.valid && decodeRecord.isBranch && !memStall;
    assign branchTarget = aluResult + 1'b1;

    always_ff @(posedge Clock, posedge Reset) begin
        if (Reset) begin
            executeRecord <= '0;
        end else if (!memStall) begin
            executeRecord        <= decodeRecord;
            executeRecord.result <= aluResult;
        end
    end

endmodule

// File: logic/decodeUnit.sv
/*
  Field split, operand read and RAW check. No forwarding: an instruction waits here
  until every older writer of its sources has written the register file.
  The check is against Execute, Memory1, Memory2 and Writeback records.
  ld and st always take rY as the address register, whatever M says.
*/
module decodeUnit (
    input  logic                         Clock,
    input  logic                         Reset,
    input  logic [cpuPkg::wordSize-1:0]  fetchedInstr,
    input  logic                         fetchedValid,
    input  logic [cpuPkg::wordSize-1:0]  fetchedPc,
    input  logic [cpuPkg::wordSize-1:0]  readDataA,
    input  logic [cpuPkg::wordSize-1:0]  readDataB,
    input  logic                         memStall,
    input  logic                         branchTaken,
    input  cpuPkg::StageRecord           executeRecord,
    input  logic [cpuPkg::regBits-1:0]   mem1Rx,
    input  logic                         mem1Writes,
    input  logic [cpuPkg::regBits-1:0]   mem2Rx,
    input  logic                         mem2Writes,
    input  logic [cpuPkg::regBits-1:0]   wbRx,
    input  logic                         wbWrites,
    output logic [cpuPkg::regBits-1:0]   readRegA,
    output logic [cpuPkg::regBits-1:0]   readRegB,
    output cpuPkg::StageRecord           decodeRecord,
    output logic                         hazardStall
);

    localparam int immBits = 9;

    logic [cpuPkg::opcodeBits-1:0] opcode;
    logic                          mFlag;
    logic [immBits-1:0]            imm;
    logic [cpuPkg::wordSize-1:0]   immExt;
    logic                          isBranch;
    logic                          readsX;  // rX is a source operand
    logic                          readsY;  // register-form second operand
    logic [4:0]                    pendValid;
    logic [4:0][cpuPkg::regBits-1:0] pendReg;
    cpuPkg::StageRecord            nextRecord;

    assign opcode   = fetchedInstr[cpuPkg::wordSize-1 -: cpuPkg::opcodeBits];
    assign mFlag    = fetchedInstr[cpuPkg::wordSize-cpuPkg::opcodeBits-1];
    assign readRegA = fetchedInstr[cpuPkg::wordSize-cpuPkg::opcodeBits-2 -: cpuPkg::regBits];
    assign readRegB = fetchedInstr[cpuPkg::regBits-1:0];
    assign imm      = fetchedInstr[immBits-1:0];
    assign immExt   = {{(cpuPkg::wordSize-immBits){imm[immBits-1]}}, imm}; // sign extend

    assign isBranch = opcode == cpuPkg::opMvtB && !mFlag;
    assign readsX   = opcode inside {cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd, cpuPkg::opSt};
    assign readsY   = opcode inside {cpuPkg::opLd, cpuPkg::opSt}
                   || (!mFlag && opcode inside {cpuPkg::opMv, cpuPkg::opAdd, cpuPkg::opSub,
                                                cpuPkg::opAnd});

    always_comb begin
        nextRecord          = '0;
        nextRecord.valid    = 1'b1;
        nextRecord.rX       = readRegA;
        nextRecord.rY       = readRegB;
        nextRecord.isBranch = isBranch;
        nextRecord.read     = opcode == cpuPkg::opLd;
        nextRecord.write    = opcode == cpuPkg::opSt;
        nextRecord.op1      = isBranch ? fetchedPc : readDataA; // branch base is its own address
        if (opcode == cpuPkg::opMvtB)
            nextRecord.op2 = isBranch ? immExt : {imm[7:0], 8'h00}; // mvt fills upper byte
        else
            nextRecord.op2 = readsY ? readDataB : immExt;
        case (opcode)
            cpuPkg::opMv:   nextRecord.aluOp = cpuPkg::aluMov;
            cpuPkg::opMvtB: nextRecord.aluOp = isBranch ? cpuPkg::aluAdd : cpuPkg::aluMov;
            cpuPkg::opAdd:  nextRecord.aluOp = cpuPkg::aluAdd;
            cpuPkg::opSub:  nextRecord.aluOp = cpuPkg::aluSub;
            cpuPkg::opAnd:  nextRecord.aluOp = cpuPkg::aluAnd;
            default:        nextRecord.aluOp = cpuPkg::aluNone;
        endcase
        // st, b and opOther write nothing, r7 is never a target
        nextRecord.writeback = !isBranch && readRegA != 3'd7
                            && !(opcode inside {cpuPkg::opSt, cpuPkg::opOther});
    end

    // pending writers, youngest first
    assign pendValid = {decodeRecord.valid && decodeRecord.writeback,
                        executeRecord.valid && executeRecord.writeback,
                        mem1Writes, mem2Writes, wbWrites};
    assign pendReg   = {decodeRecord.rX, executeRecord.rX, mem1Rx, mem2Rx, wbRx};

    always_comb begin
        hazardStall = 1'b0;
        for (int i = 0; i < 5; i++) begin
            if (pendValid[i] && ((readsX && pendReg[i] == readRegA)
                              || (readsY && pendReg[i] == readRegB)))
                hazardStall = fetchedValid;
        end
    end

    always_ff @(posedge Clock, posedge Reset) begin
        if (Reset)
            decodeRecord <= '0;
        else if (branchTaken)
            decodeRecord <= '0;                  // flush the wrong-path instruction
        else if (!memStall)
            decodeRecord <= (hazardStall || !fetchedValid) ? '0 : nextRecord; // bubble on RAW
    end

    // a redirect drops the held Fetch word too, so two bubbles follow the branch
    flushNotHeld: assert property (@(posedge Clock) disable iff (Reset)
        branchTaken |=> !fetchedValid ##1 !decodeRecord.valid);

endmodule

// File: logic/fetchUnit.sv
/*
  PC and Fetch stage register. The instruction memory answers one cycle after the address.
  While stalled the address of the word in flight is presented again, so no word is lost.
  A taken branch presents its target at once, which gives two bubbles in Execute.
*/
module fetchUnit #(
    parameter logic [cpuPkg::wordSize-1:0] ResetPc = '0
) (
    input  logic                        Clock,
    input  logic                        Reset,
    input  logic [cpuPkg::wordSize-1:0] InstrIn,
    input  logic                        hazardStall,
    input  logic                        memStall,
    input  logic                        branchTaken,
    input  logic [cpuPkg::wordSize-1:0] branchTarget,
    output logic [cpuPkg::wordSize-1:0] InstrAddr,
    output logic [cpuPkg::wordSize-1:0] fetchedInstr,
    output logic                        fetchedValid,
    output logic [cpuPkg::wordSize-1:0] fetchedPc
);

    logic [cpuPkg::wordSize-1:0] pc;          // next address to request
    logic [cpuPkg::wordSize-1:0] inFlightPc;  // address of the word now on InstrIn
    logic                        inFlightValid;
    logic                        stall;

    assign stall = hazardStall || memStall;

    // redirect wins, a stall repeats the in-flight request
    assign InstrAddr = branchTaken ? branchTarget : (stall ? inFlightPc : pc);

    always_ff @(posedge Clock, posedge Reset) begin
        if (Reset) begin
            pc            <= ResetPc;
            inFlightPc    <= ResetPc;
            inFlightValid <= 1'b0;
            fetchedValid  <= 1'b0;
        end else if (branchTaken) begin
            pc            <= branchTarget + 1'b1; // target already requested this cycle
            inFlightPc    <= branchTarget;
            inFlightValid <= 1'b1;
            fetchedValid  <= 1'b0;                // drop the wrong-path word
        end else if (!stall) begin
            pc            <= pc + 1'b1;
            inFlightPc    <= pc;
            inFlightValid <= 1'b1;
            fetchedValid  <= inFlightValid;
        end
    end

    // payload only
    always_ff @(posedge Clock) begin
        if (!stall && !branchTaken) begin
            fetchedInstr <= InstrIn;
            fetchedPc    <= inFlightPc;
        end
    end

endmodule

// File: logic/registerFile.sv
/*
  General registers r0-r6. Reads are combinational, the write lands at the clock edge.
  Index 7 reads as zero. Decode never marks r7 as a writeback target.
*/
module registerFile (
    input  logic                         Clock,
    input  logic                         Reset,
    input  logic [cpuPkg::regBits-1:0]   readRegA,
    input  logic [cpuPkg::regBits-1:0]   readRegB,
    input  logic                         writeEnable,
    input  logic [cpuPkg::regBits-1:0]   writeReg,
    input  logic [cpuPkg::wordSize-1:0]  writeValue,
    output logic [cpuPkg::wordSize-1:0]  readDataA,
    output logic [cpuPkg::wordSize-1:0]  readDataB
);

    localparam logic [cpuPkg::regBits-1:0] zeroReg = cpuPkg::regBits'(cpuPkg::numRegs - 1);

    logic [cpuPkg::wordSize-1:0] regs [cpuPkg::numRegs-1]; // r0..r6 only

    always_ff @(posedge Clock, posedge Reset) begin
        if (Reset) begin
            for (int i = 0; i < cpuPkg::numRegs - 1; i++)
                regs[i] <= '0;
        end else if (writeEnable && writeReg != zeroReg) begin
            regs[writeReg] <= writeValue;
        end
    end

    assign readDataA = (readRegA == zeroReg) ? '0 : regs[readRegA]; // r7 reads zero
    assign readDataB = (readRegB == zeroReg) ? '0 : regs[readRegB];

    // decode is expected to filter r7 targets before they reach writeback
    writeNotR7: assert property (@(posedge Clock) disable iff (Reset)
        writeEnable |-> writeReg != zeroReg);

endmodule

// File: logic/cpuPkg.sv
/*
  Shared sizes, opcode encodings and the record that moves between pipeline stages.
  Instruction layout is III M XXX DDDDDDDDD, or III M XXX 000000 YYY for register form.
  r7 is not a real register. It reads as zero and is never written.
*/
package cpuPkg;

    parameter int wordSize   = 16;
    parameter int numRegs    = 8;
    parameter int regBits    = $clog2(numRegs);
    parameter int opcodeBits = 3;

    // opcode field, bits 15:13
    parameter logic [opcodeBits-1:0] opMv    = 3'b000;
    parameter logic [opcodeBits-1:0] opMvtB  = 3'b001; // mvt when M set, b when clear
    parameter logic [opcodeBits-1:0] opAdd   = 3'b010;
    parameter logic [opcodeBits-1:0] opSub   = 3'b011;
    parameter logic [opcodeBits-1:0] opLd    = 3'b100;
    parameter logic [opcodeBits-1:0] opSt    = 3'b101;
    parameter logic [opcodeBits-1:0] opAnd   = 3'b110;
    parameter logic [opcodeBits-1:0] opOther = 3'b111; // retires as no-op

    typedef enum logic [2:0] {
        aluNone,
        aluMov, // result = op2
        aluAdd,
        aluSub,
        aluAnd
    } AluOp;

    // one record per stage register, all fields zero is a bubble
    typedef struct packed {
        logic                valid;     // clear means bubble
        logic [regBits-1:0]  rX;        // destination, also store data source
        logic [regBits-1:0]  rY;
        logic [wordSize-1:0] op1;       // rX value, or PC for a branch
        logic [wordSize-1:0] op2;       // rY value or immediate, memory address for ld/st
        logic [wordSize-1:0] result;    // ALU result, load data after Memory2
        AluOp                aluOp;
        logic                isBranch;
        logic                read;      // ld
        logic                write;     // st
        logic                writeback; // result goes to rX
    } StageRecord;

endpackage
